// ==== include/sysbus_consts.svh ====
`ifndef SYSBUS_CONSTS_SVH
`define SYSBUS_CONSTS_SVH

// one bus beat and its tag
`define SYSBUS_DATA_WIDTH 64
`define SYSBUS_TAG_WIDTH 13

// a cache line moves as eight beats
`define SYSBUS_LINE_WIDTH 512
`define SYSBUS_BEATS 8

// tag bit set on a write request
`define SYSBUS_WRITE_BIT 12

// behavioral memory size and read latency in cycles
`define SYSBUS_MEM_LINES 16
`define SYSBUS_MEM_LATENCY 4

`endif

// ==== hw/sysbus_pkg.sv ====
`include "sysbus_consts.svh"

package sysbus_pkg;

    // arbiter transaction states
    typedef enum logic [3:0] {
        ARB_IDLE,
        ARB_ACK_REQ,
        ARB_GET_DATA,
        ARB_ACK_DATA,
        ARB_MEM_ADDR,
        ARB_MEM_WRITE,
        ARB_MEM_ADDR_RD,
        ARB_MEM_READ,
        ARB_RESPOND
    } arb_state_t;

    // memory model states
    typedef enum logic [2:0] {
        MEM_IDLE,
        MEM_ACK_ADDR,
        MEM_TAKE_DATA,
        MEM_WAIT,
        MEM_SEND
    } mem_state_t;

    // decoded from the write bit of the tag
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } bus_op_t;

    typedef struct packed {
        logic [`SYSBUS_DATA_WIDTH-1:0] data;
        logic [`SYSBUS_TAG_WIDTH-1:0]  tag;
    } bus_word_t;

    typedef struct packed {
        logic        write;
        logic [1:0]  addr;
        logic [31:0] wdata;
    } cfg_req_t;

endpackage

// ==== hw/line_buffer.sv ====
`include "sysbus_consts.svh"

module line_buffer (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          clear,
    input  logic                          load,
    input  logic                          step,
    input  logic [`SYSBUS_DATA_WIDTH-1:0] wdata,
    output logic [`SYSBUS_DATA_WIDTH-1:0] rdata,
    output logic                          last
);

    localparam int PTR_W = $clog2(`SYSBUS_BEATS);

    logic [`SYSBUS_LINE_WIDTH-1:0] line;
    logic [PTR_W-1:0]              ptr;

    // beat pointer, wraps to zero after beat 7
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr <= '0;
        end else if (clear) begin
            ptr <= '0;
        end else if (step) begin
            ptr <= ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            line[ptr * `SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH] <= wdata;
        end
    end

    assign rdata = line[ptr * `SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH];
    assign last  = (ptr == PTR_W'(`SYSBUS_BEATS - 1));

    // a load during clear would land on a stale beat slot
    load_clear_excl: assert property (
        @(posedge clk) disable iff (reset) !(load && clear)
    );

endmodule

// ==== hw/bus_arbiter.sv ====
`include "sysbus_consts.svh"

module bus_arbiter
    import sysbus_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,

    // requesters, channel 0 fetch and channel 1 data
    input  logic                          reqcyc_0,
    input  logic                          reqcyc_1,
    input  logic                          respack_0,
    input  logic                          respack_1,
    input  bus_word_t                     req_0,
    input  bus_word_t                     req_1,
    output logic                          reqack_0,
    output logic                          reqack_1,
    output logic                          respcyc_0,
    output logic                          respcyc_1,
    output bus_word_t                     resp_0,
    output bus_word_t                     resp_1,

    // config block
    input  logic                          prefer_ch1,
    output logic                          grant_valid,
    output logic                          grant_ch,

    // memory bus
    output logic                          bus_reqcyc,
    output logic                          bus_respack,
    output bus_word_t                     bus_req,
    input  logic                          bus_reqack,
    input  logic                          bus_respcyc,
    input  bus_word_t                     bus_resp,

    // line buffer
    output logic                          buf_load,
    output logic                          buf_clear,
    output logic                          buf_step,
    output logic [`SYSBUS_DATA_WIDTH-1:0] buf_wdata,
    input  logic [`SYSBUS_DATA_WIDTH-1:0] buf_rdata,
    input  logic                          buf_last
);

    arb_state_t state;
    arb_state_t state_next;
    bus_op_t    op;

    logic                          channel;
    logic                          take_ch1;
    logic [`SYSBUS_DATA_WIDTH-1:0] addr_q;
    logic [`SYSBUS_TAG_WIDTH-1:0]  tag_q;
    logic                          acked_ch;

    bus_word_t cur_req;
    logic      cur_reqcyc;
    logic      cur_respack;
    logic      acking;

    // both requesting: config decides
    assign take_ch1 = reqcyc_1 && (!reqcyc_0 || prefer_ch1);

    // granted channel's side of the handshake
    assign cur_req     = channel ? req_1 : req_0;
    assign cur_reqcyc  = channel ? reqcyc_1 : reqcyc_0;
    assign cur_respack = channel ? respack_1 : respack_0;

    assign op = tag_q[`SYSBUS_WRITE_BIT] ? OP_WRITE : OP_READ;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= ARB_IDLE;
            channel <= 1'b0;
        end else begin
            state <= state_next;
            if (state == ARB_IDLE && (reqcyc_0 || reqcyc_1)) begin
                channel <= take_ch1;
            end
        end
    end

    // address and tag of the accepted request
    always_ff @(posedge clk) begin
        if (state == ARB_IDLE && (reqcyc_0 || reqcyc_1)) begin
            addr_q <= take_ch1 ? req_1.data : req_0.data;
            tag_q  <= take_ch1 ? req_1.tag : req_0.tag;
        end
    end

    // channel that saw the request ack of this transaction
    always_ff @(posedge clk) begin
        if (grant_valid) begin
            acked_ch <= reqack_1;
        end
    end

    always_comb begin
        state_next  = state;
        buf_load    = 1'b0;
        buf_clear   = 1'b0;
        buf_step    = 1'b0;
        buf_wdata   = cur_req.data;
        bus_respack = 1'b0;
        case (state)
            ARB_IDLE: begin
                if (reqcyc_0 || reqcyc_1) begin
                    state_next = ARB_ACK_REQ;
                end
            end
            ARB_ACK_REQ: begin
                buf_clear  = 1'b1;
                state_next = (op == OP_WRITE) ? ARB_GET_DATA : ARB_MEM_ADDR_RD;
            end
            ARB_GET_DATA: begin
                if (cur_reqcyc) begin
                    buf_load   = 1'b1;
                    state_next = ARB_ACK_DATA;
                end
            end
            ARB_ACK_DATA: begin
                // pointer wraps to beat 0 for the memory phase
                buf_step   = 1'b1;
                state_next = buf_last ? ARB_MEM_ADDR : ARB_GET_DATA;
            end
            ARB_MEM_ADDR: begin
                if (bus_reqack) begin
                    state_next = ARB_MEM_WRITE;
                end
            end
            ARB_MEM_WRITE: begin
                if (bus_reqack) begin
                    buf_step = 1'b1;
                    if (buf_last) begin
                        state_next = ARB_IDLE;
                    end
                end
            end
            ARB_MEM_ADDR_RD: begin
                if (bus_reqack) begin
                    state_next = ARB_MEM_READ;
                end
            end
            ARB_MEM_READ: begin
                if (bus_respcyc) begin
                    bus_respack = 1'b1;
                    buf_load    = 1'b1;
                    buf_wdata   = bus_resp.data;
                    buf_step    = 1'b1;
                    if (buf_last) begin
                        state_next = ARB_RESPOND;
                    end
                end
            end
            ARB_RESPOND: begin
                if (cur_respack) begin
                    buf_step = 1'b1;
                    if (buf_last) begin
                        state_next = ARB_IDLE;
                    end
                end
            end
            default: state_next = ARB_IDLE;
        endcase
    end

    // acks are a state of their own, one cycle after capture
    assign acking   = (state == ARB_ACK_REQ) || (state == ARB_ACK_DATA);
    assign reqack_0 = acking && !channel;
    assign reqack_1 = acking && channel;

    assign respcyc_0 = (state == ARB_RESPOND) && !channel;
    assign respcyc_1 = (state == ARB_RESPOND) && channel;
    assign resp_0    = '{data: buf_rdata, tag: tag_q};
    assign resp_1    = '{data: buf_rdata, tag: tag_q};

    assign grant_valid = (state == ARB_ACK_REQ);
    assign grant_ch    = channel;

    assign bus_reqcyc = (state == ARB_MEM_ADDR) || (state == ARB_MEM_WRITE)
                        || (state == ARB_MEM_ADDR_RD);
    assign bus_req.data = (state == ARB_MEM_WRITE) ? buf_rdata : addr_q;
    assign bus_req.tag  = tag_q;

    one_reqack: assert property (
        @(posedge clk) disable iff (reset) !(reqack_0 && reqack_1)
    );

    // response only goes to the channel whose request was acked
    resp_to_granted: assert property (
        @(posedge clk) disable iff (reset)
        (respcyc_0 || respcyc_1) |-> (respcyc_1 == acked_ch)
    );

    bus_req_held: assert property (
        @(posedge clk) disable iff (reset)
        bus_reqcyc && !bus_reqack |=> bus_reqcyc
    );

endmodule

// ==== hw/arb_config.sv ====
module arb_config
    import sysbus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  cfg_req_t    cfg,
    output logic [31:0] cfg_rdata,
    input  logic        grant_valid,
    input  logic        grant_ch,
    output logic        prefer_ch1
);

    logic        mode_rr;
    logic        last_ch;
    logic [31:0] count_0;
    logic [31:0] count_1;

    always_ff @(posedge clk) begin
        if (reset) begin
            mode_rr <= 1'b0;
            // treat channel 1 as last so round-robin opens on channel 0
            last_ch <= 1'b1;
            count_0 <= '0;
            count_1 <= '0;
        end else begin
            if (grant_valid) begin
                last_ch <= grant_ch;
                if (grant_ch) begin
                    count_1 <= count_1 + 1'b1;
                end else begin
                    count_0 <= count_0 + 1'b1;
                end
            end
            // a write to a counter address clears it
            if (cfg.write) begin
                case (cfg.addr)
                    2'd0: mode_rr <= cfg.wdata[0];
                    2'd1: count_0 <= '0;
                    2'd2: count_1 <= '0;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (cfg.addr)
            2'd0:    cfg_rdata = {31'b0, mode_rr};
            2'd1:    cfg_rdata = count_0;
            2'd2:    cfg_rdata = count_1;
            default: cfg_rdata = '0;
        endcase
    end

    // fixed mode always favours channel 0
    assign prefer_ch1 = mode_rr && !last_ch;

endmodule

// ==== hw/line_memory.sv ====
`include "sysbus_consts.svh"

module line_memory
    import sysbus_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      bus_reqcyc,
    input  logic      bus_respack,
    input  bus_word_t bus_req,
    output logic      bus_reqack,
    output logic      bus_respcyc,
    output bus_word_t bus_resp
);

    localparam int IDX_W  = $clog2(`SYSBUS_MEM_LINES);
    localparam int BEAT_W = $clog2(`SYSBUS_BEATS);

    logic [`SYSBUS_LINE_WIDTH-1:0] mem [`SYSBUS_MEM_LINES];

    mem_state_t                   state;
    bus_op_t                      op;
    logic [IDX_W-1:0]             line_idx;
    logic [`SYSBUS_TAG_WIDTH-1:0] tag_q;
    logic [BEAT_W-1:0]            beat;
    logic [3:0]                   wait_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= MEM_IDLE;
            bus_reqack <= 1'b0;
            beat       <= '0;
            wait_cnt   <= '0;
        end else begin
            bus_reqack <= 1'b0;
            case (state)
                MEM_IDLE: begin
                    if (bus_reqcyc) begin
                        bus_reqack <= 1'b1;
                        state      <= MEM_ACK_ADDR;
                    end
                end
                MEM_ACK_ADDR: begin
                    beat     <= '0;
                    // first beat lands latency cycles after the address ack
                    wait_cnt <= 4'(`SYSBUS_MEM_LATENCY - 2);
                    state    <= (op == OP_WRITE) ? MEM_TAKE_DATA : MEM_WAIT;
                end
                MEM_TAKE_DATA: begin
                    if (bus_reqack) begin
                        beat <= beat + 1'b1;
                        if (beat == BEAT_W'(`SYSBUS_BEATS - 1)) begin
                            state <= MEM_IDLE;
                        end
                    end else if (bus_reqcyc) begin
                        bus_reqack <= 1'b1;
                    end
                end
                MEM_WAIT: begin
                    if (wait_cnt == '0) begin
                        state <= MEM_SEND;
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                MEM_SEND: begin
                    if (bus_respack) begin
                        beat <= beat + 1'b1;
                        if (beat == BEAT_W'(`SYSBUS_BEATS - 1)) begin
                            state <= MEM_IDLE;
                        end
                    end
                end
                default: state <= MEM_IDLE;
            endcase
        end
    end

    // request details latched with the address beat
    always_ff @(posedge clk) begin
        if (state == MEM_IDLE && bus_reqcyc) begin
            line_idx <= bus_req.data[6 +: IDX_W];
            tag_q    <= bus_req.tag;
            op       <= bus_req.tag[`SYSBUS_WRITE_BIT] ? OP_WRITE : OP_READ;
        end
        if (state == MEM_TAKE_DATA && bus_reqack) begin
            mem[line_idx][beat * `SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH] <= bus_req.data;
        end
    end

    assign bus_respcyc   = (state == MEM_SEND);
    assign bus_resp.data = mem[line_idx][beat * `SYSBUS_DATA_WIDTH +: `SYSBUS_DATA_WIDTH];
    assign bus_resp.tag  = tag_q;

endmodule

// ==== hw/mem_subsystem_top.sv ====
`include "sysbus_consts.svh"

module mem_subsystem_top
    import sysbus_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        reqcyc_0,
    input  logic        reqcyc_1,
    input  logic        respack_0,
    input  logic        respack_1,
    input  bus_word_t   req_0,
    input  bus_word_t   req_1,
    output logic        reqack_0,
    output logic        reqack_1,
    output logic        respcyc_0,
    output logic        respcyc_1,
    output bus_word_t   resp_0,
    output bus_word_t   resp_1,
    input  cfg_req_t    cfg,
    output logic [31:0] cfg_rdata
);

    // memory bus
    logic      bus_reqcyc;
    logic      bus_reqack;
    logic      bus_respcyc;
    logic      bus_respack;
    bus_word_t bus_req;
    bus_word_t bus_resp;

    // line buffer
    logic                          buf_load;
    logic                          buf_clear;
    logic                          buf_step;
    logic                          buf_last;
    logic [`SYSBUS_DATA_WIDTH-1:0] buf_wdata;
    logic [`SYSBUS_DATA_WIDTH-1:0] buf_rdata;

    // arbitration control
    logic prefer_ch1;
    logic grant_valid;
    logic grant_ch;

    bus_arbiter bus_arbiter_inst (
        .clk,
        .reset,
        .reqcyc_0,
        .reqcyc_1,
        .respack_0,
        .respack_1,
        .req_0,
        .req_1,
        .reqack_0,
        .reqack_1,
        .respcyc_0,
        .respcyc_1,
        .resp_0,
        .resp_1,
        .prefer_ch1,
        .grant_valid,
        .grant_ch,
        .bus_reqcyc,
        .bus_respack,
        .bus_req,
        .bus_reqack,
        .bus_respcyc,
        .bus_resp,
        .buf_load,
        .buf_clear,
        .buf_step,
        .buf_wdata,
        .buf_rdata,
        .buf_last
    );

    line_buffer line_buffer_inst (
        .clk,
        .reset,
        .clear (buf_clear),
        .load  (buf_load),
        .step  (buf_step),
        .wdata (buf_wdata),
        .rdata (buf_rdata),
        .last  (buf_last)
    );

    arb_config arb_config_inst (
        .clk,
        .reset,
        .cfg,
        .cfg_rdata,
        .grant_valid,
        .grant_ch,
        .prefer_ch1
    );

    line_memory line_memory_inst (
        .clk,
        .reset,
        .bus_reqcyc,
        .bus_respack,
        .bus_req,
        .bus_reqack,
        .bus_respcyc,
        .bus_resp
    );

endmodule

// ==== bench/mem_subsystem_tb.sv ====
`include "sysbus_consts.svh"

module mem_subsystem_tb
    import sysbus_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    // transactions issued over all tests, rounded up
    localparam int TXN_COUNT        = 20;
    localparam int WORST_TXN_CYCLES = 100;
    localparam int WATCHDOG_CYCLES  = TXN_COUNT * WORST_TXN_CYCLES * 2;
    localparam int BEAT_W           = `SYSBUS_DATA_WIDTH;

    logic        clk;
    logic        reset;
    logic        reqcyc [2];
    logic        respack [2];
    bus_word_t   req [2];
    logic        reqack [2];
    logic        respcyc [2];
    bus_word_t   resp [2];
    cfg_req_t    cfg;
    logic [31:0] cfg_rdata;

    logic [31:0] lfsr;
    logic [10:0] tag_serial;
    // scoreboard copy of the line memory
    logic [`SYSBUS_LINE_WIDTH-1:0] sb_mem [`SYSBUS_MEM_LINES];
    logic                          sb_written [`SYSBUS_MEM_LINES];
    int  grants_issued [2];
    time ack_time [2];
    time done_time [2];
    int  grant_order [$];

    mem_subsystem_top mem_subsystem_top_inst (
        .clk,
        .reset,
        .reqcyc_0  (reqcyc[0]),
        .reqcyc_1  (reqcyc[1]),
        .respack_0 (respack[0]),
        .respack_1 (respack[1]),
        .req_0     (req[0]),
        .req_1     (req[1]),
        .reqack_0  (reqack[0]),
        .reqack_1  (reqack[1]),
        .respcyc_0 (respcyc[0]),
        .respcyc_1 (respcyc[1]),
        .resp_0    (resp[0]),
        .resp_1    (resp[1]),
        .cfg,
        .cfg_rdata
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_run($sformatf("watchdog expired at %0t, the DUT stopped answering", $time));
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else
            fail_run($sformatf("[ERROR] time=%0t signal=%s expected=%0h actual=%0h",
                               $time, name, expected, actual));
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else
            fail_run($sformatf("at %0t: %s", $time, what));
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[62:0], lfsr_bit()};
        end
        return value;
    endfunction

    function automatic logic [`SYSBUS_LINE_WIDTH-1:0] rand_line();
        logic [`SYSBUS_LINE_WIDTH-1:0] line;
        for (int b = 0; b < `SYSBUS_BEATS; b++) begin
            line[b * BEAT_W +: BEAT_W] = rand_bits(64);
        end
        return line;
    endfunction

    // write flag, channel, then a running serial
    function automatic logic [`SYSBUS_TAG_WIDTH-1:0] make_tag(input int ch, input logic write);
        tag_serial = tag_serial + 1'b1;
        return {write, ch[0], tag_serial};
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        grants_issued[0] = 0;
        grants_issued[1] = 0;
    endtask

    // always at least one cycle, the ack is registered
    task automatic wait_reqack(input int ch);
        do @(negedge clk); while (!reqack[ch]);
    endtask

    task automatic write_line(input int ch, input int idx,
                              input logic [`SYSBUS_LINE_WIDTH-1:0] line, input logic stall);
        int gap;
        req[ch].data = 64'(idx * 64);
        req[ch].tag  = make_tag(ch, 1'b1);
        reqcyc[ch]   = 1'b1;
        wait_reqack(ch);
        for (int b = 0; b < `SYSBUS_BEATS; b++) begin
            gap = stall ? int'(rand_bits(2)) : 0;
            if (gap > 0) begin
                reqcyc[ch] = 1'b0;
                repeat (gap) @(negedge clk);
            end
            req[ch].data = line[b * BEAT_W +: BEAT_W];
            reqcyc[ch]   = 1'b1;
            wait_reqack(ch);
        end
        reqcyc[ch]      = 1'b0;
        sb_mem[idx]     = line;
        sb_written[idx] = 1'b1;
        grants_issued[ch]++;
    endtask

    task automatic read_line(input int ch, input int idx, input logic stall);
        logic [`SYSBUS_TAG_WIDTH-1:0]  tag;
        logic [`SYSBUS_LINE_WIDTH-1:0] expected;
        int                            gap;
        check_true(sb_written[idx], "a read was issued for a line that was never written");
        expected     = sb_mem[idx];
        tag          = make_tag(ch, 1'b0);
        req[ch].data = 64'(idx * 64);
        req[ch].tag  = tag;
        reqcyc[ch]   = 1'b1;
        wait_reqack(ch);
        ack_time[ch] = $time;
        grant_order.push_back(ch);
        reqcyc[ch] = 1'b0;
        for (int b = 0; b < `SYSBUS_BEATS; b++) begin
            while (!respcyc[ch]) @(negedge clk);
            gap = stall ? int'(rand_bits(2)) : 0;
            repeat (gap) @(negedge clk);
            check_true(respcyc[ch], "response was withdrawn while respack was held low");
            check_value($sformatf("resp_%0d.data beat %0d", ch, b),
                        expected[b * BEAT_W +: BEAT_W], resp[ch].data);
            check_value($sformatf("resp_%0d.tag", ch), 64'(tag), 64'(resp[ch].tag));
            respack[ch] = 1'b1;
            @(negedge clk);
            respack[ch] = 1'b0;
        end
        done_time[ch] = $time;
        grants_issued[ch]++;
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
        cfg = '{write: 1'b1, addr: addr, wdata: data};
        @(negedge clk);
        cfg.write = 1'b0;
    endtask

    // rdata is combinational, sample a quarter period after the address
    task automatic cfg_read(input logic [1:0] addr, output logic [31:0] data);
        cfg.write = 1'b0;
        cfg.addr  = addr;
        #(CLK_PERIOD / 4);
        data = cfg_rdata;
        @(negedge clk);
    endtask

    task automatic test_reset_state();
        logic [31:0] value;
        for (int ch = 0; ch < 2; ch++) begin
            check_value($sformatf("reqack_%0d", ch), 64'(0), 64'(reqack[ch]));
            check_value($sformatf("respcyc_%0d", ch), 64'(0), 64'(respcyc[ch]));
        end
        for (int a = 0; a < 3; a++) begin
            cfg_read(2'(a), value);
            check_value($sformatf("cfg_rdata at %0d", a), 64'(0), 64'(value));
        end
    endtask

    task automatic test_write_read();
        for (int i = 0; i < 4; i++) begin
            write_line(1, 3 * i + 1, rand_line(), 1'b0);
            read_line(0, 3 * i + 1, 1'b0);
        end
    endtask

    task automatic test_fixed_priority();
        fork
            read_line(0, 1, 1'b0);
            read_line(1, 4, 1'b0);
        join
        check_true(ack_time[0] < ack_time[1], "channel 1 was acked before channel 0");
        check_true(ack_time[1] > done_time[0], "channel 1 was granted during channel 0's read");
    endtask

    task automatic test_round_robin();
        // after reset the last grant counts as channel 1
        apply_reset();
        cfg_write(2'd0, 32'd1);
        grant_order.delete();
        fork
            begin
                read_line(0, 7, 1'b0);
                read_line(0, 1, 1'b0);
            end
            begin
                read_line(1, 10, 1'b0);
                read_line(1, 4, 1'b0);
            end
        join
        for (int i = 0; i < grant_order.size(); i++) begin
            check_value($sformatf("granted channel %0d", i), 64'(i % 2), 64'(grant_order[i]));
        end
    endtask

    task automatic test_back_pressure();
        write_line(0, 13, rand_line(), 1'b1);
        read_line(1, 13, 1'b1);
        write_line(1, 15, rand_line(), 1'b1);
        read_line(0, 15, 1'b1);
    endtask

    task automatic test_grant_counters();
        logic [31:0] value;
        cfg_read(2'd1, value);
        check_value("grant count 0", 64'(grants_issued[0]), 64'(value));
        cfg_read(2'd2, value);
        check_value("grant count 1", 64'(grants_issued[1]), 64'(value));
        cfg_write(2'd1, 32'd0);
        cfg_read(2'd1, value);
        check_value("grant count 0 after clear", 64'(0), 64'(value));
        cfg_read(2'd2, value);
        check_value("grant count 1 after clear", 64'(grants_issued[1]), 64'(value));
    endtask

    initial begin
        lfsr       = 32'h26fb;
        tag_serial = '0;
        reset      = 1'b1;
        cfg        = '0;
        for (int ch = 0; ch < 2; ch++) begin
            reqcyc[ch]  = 1'b0;
            respack[ch] = 1'b0;
            req[ch]     = '0;
        end
        for (int i = 0; i < `SYSBUS_MEM_LINES; i++) begin
            sb_written[i] = 1'b0;
        end
        apply_reset();
        test_reset_state();
        test_write_read();
        test_fixed_priority();
        test_round_robin();
        test_back_pressure();
        test_grant_counters();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+include
hw/sysbus_pkg.sv
hw/line_buffer.sv
hw/bus_arbiter.sv
hw/arb_config.sv
hw/line_memory.sv
hw/mem_subsystem_top.sv
bench/mem_subsystem_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= mem_subsystem_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
